// ==== tb.f ====
common/fractal_pkg.sv
fma/fma_lane.sv
fma/fma_array.sv
video/video_timing.sv
video/frame_buffer.sv
logic/fractal_top.sv
testbench/fractal_checker.sv
testbench/tb_fractal.sv

// ==== Bender.yml ====
package:
  name: fractal

sources:
  - files:
      - common/fractal_pkg.sv
      - fma/fma_lane.sv
      - fma/fma_array.sv
      - video/video_timing.sv
      - video/frame_buffer.sv
      - logic/fractal_top.sv
  - target: test
    files:
      - testbench/fractal_checker.sv
      - testbench/tb_fractal.sv

// ==== testbench/tb_fractal.sv ====
`timescale 1ns/10ps

module tb_fractal import fractal_pkg::*; ();

    typedef enum logic [1:0] {OPERAND, ITERS_WRITE, SWAP_BANKS, WAIT_FRAME} kind_e;

    typedef struct packed {
        logic [7:0]                    test;
        kind_e                         kind;
        logic                          new_c;
        logic                          stall;   // Random backpressure on results
        logic                          drain;   // Wait for the result before moving on
        logic [OPERAND_LINE_WIDTH-1:0] line;
        logic [FB_ADDR_WIDTH-1:0]      addr;
        logic [ITERS_GROUP_WIDTH-1:0]  group;
    } stim_t;

    logic clk_pixel = 1'b0;
    logic sys_rst;
    logic operand_valid;
    logic operand_ready;
    logic [OPERAND_LINE_WIDTH-1:0] operand_line;
    logic use_new_c;
    logic result_valid;
    logic result_ready;
    logic [RESULT_LINE_WIDTH-1:0] result_line;
    logic iters_valid;
    logic [FB_ADDR_WIDTH-1:0] iters_addr;
    logic [ITERS_GROUP_WIDTH-1:0] iters_group;
    logic swap;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic hsync;
    logic vsync;
    logic active;

    logic stall_mode = 1'b0;
    logic test_done  = 1'b0;
    int done_num     = 0;
    int test_num     = 1;
    int pending;
    int error_total;
    int stall_left   = 0;
    int cycles       = 0;
    int timeout_limit;
    logic [15:0] lfsr_state = 16'd27;
    stim_t stimulus [$];

    always #2 clk_pixel = ~clk_pixel;

    fractal_top fractal_top_i (.*);

    fractal_checker checker_i (.*, .rgb({red, green, blue}), .test_num(done_num));

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[62:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return bits;
    endfunction

    function automatic logic [OPERAND_LINE_WIDTH-1:0] random_line();
        logic [OPERAND_LINE_WIDTH-1:0] line;
        for (int i = 0; i < OPERAND_LINE_WIDTH / 64; i++) begin
            line = {line[OPERAND_LINE_WIDTH-65:0], random_bits(64)};
        end
        return line;
    endfunction

    task automatic add_record(input int test, input kind_e kind, input logic [2:0] flags,
                              input int addr);
        stim_t rec;
        rec.test  = 8'(test);
        rec.kind  = kind;
        {rec.new_c, rec.stall, rec.drain} = flags;    // new_c, stall, drain
        rec.line  = random_line();
        rec.addr  = FB_ADDR_WIDTH'(addr);
        rec.group = random_bits(64);
        stimulus.push_back(rec);
    endtask

    task automatic wait_idle();
        @(negedge clk_pixel);
        while (pending != 0) @(negedge clk_pixel);
        @(posedge clk_pixel);
    endtask

    task automatic finish_test();
        operand_valid <= 1'b0;
        wait_idle();
        test_done <= 1'b1;
        done_num  <= test_num;
        @(posedge clk_pixel);
        test_done <= 1'b0;
    endtask

    task automatic apply(input stim_t rec);
        stall_mode <= rec.stall;
        case (rec.kind)
            OPERAND: begin
                operand_valid <= 1'b1;
                operand_line  <= rec.line;
                use_new_c     <= rec.new_c;
                do @(posedge clk_pixel); while (!operand_ready);
                operand_valid <= 1'b0;
                if (rec.drain) begin
                    wait_idle();
                end
            end
            ITERS_WRITE: begin
                iters_valid <= 1'b1;
                iters_addr  <= rec.addr;
                iters_group <= rec.group;
                @(posedge clk_pixel);
                iters_valid <= 1'b0;
            end
            SWAP_BANKS: begin
                swap <= 1'b1;
                @(posedge clk_pixel);
                swap <= 1'b0;
            end
            default: begin
                @(posedge vsync);   // End of the frame on screen
                @(posedge clk_pixel);
            end
        endcase
    endtask

    // Ready dropped for 0 to 7 cycles at a time
    always @(posedge clk_pixel) begin
        if (stall_left > 0) begin
            result_ready <= 1'b0;
            stall_left   <= stall_left - 1;
        end else begin
            result_ready <= 1'b1;
            stall_left   <= stall_mode ? int'(random_bits(3)) : 0;
        end
    end

    always @(posedge clk_pixel) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Run timed out after %0d cycles before the stimulus table was done", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        sys_rst       = 1'b1;
        operand_valid = 1'b0;
        operand_line  = '0;
        use_new_c     = 1'b1;
        result_ready  = 1'b1;
        iters_valid   = 1'b0;
        iters_addr    = '0;
        iters_group   = '0;
        swap          = 1'b0;
        for (int i = 0; i < 6; i++) add_record(2, OPERAND, 3'b100, 0);
        for (int i = 0; i < 4; i++) add_record(3, OPERAND, 3'b001, 0);
        for (int i = 0; i < 8; i++) add_record(4, OPERAND, 3'b110, 0);
        add_record(5, ITERS_WRITE, 3'b000, 0);              // Top left corner
        add_record(5, ITERS_WRITE, 3'b000, 21);             // Second row, second group
        add_record(5, ITERS_WRITE, 3'b000, FB_GROUPS - 1);  // Bottom right corner
        add_record(5, SWAP_BANKS, 3'b000, 0);
        add_record(5, SWAP_BANKS, 3'b000, 0);               // Same frame, no extra toggle
        add_record(5, WAIT_FRAME, 3'b000, 0);
        add_record(5, WAIT_FRAME, 3'b000, 0);
        add_record(6, WAIT_FRAME, 3'b000, 0);
        timeout_limit = 3 * H_TOTAL * V_TOTAL + stimulus.size() * 64;

        repeat (16) @(posedge clk_pixel);
        sys_rst <= 1'b0;
        foreach (stimulus[i]) begin
            if (stimulus[i].test != test_num) begin
                finish_test();
                test_num = stimulus[i].test;
            end
            apply(stimulus[i]);
        end
        finish_test();
        @(negedge clk_pixel);
        $display("%0d tests run, %0d errors", test_num, error_total);
        if (error_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/fractal_checker.sv ====
`timescale 1ns/10ps

module fractal_checker import fractal_pkg::*; (
    input  logic                          clk_pixel,
    input  logic                          sys_rst,
    input  logic                          operand_valid,
    input  logic                          operand_ready,
    input  logic [OPERAND_LINE_WIDTH-1:0] operand_line,
    input  logic                          use_new_c,
    input  logic                          result_valid,
    input  logic                          result_ready,
    input  logic [RESULT_LINE_WIDTH-1:0]  result_line,
    input  logic                          iters_valid,
    input  logic [FB_ADDR_WIDTH-1:0]      iters_addr,
    input  logic [ITERS_GROUP_WIDTH-1:0]  iters_group,
    input  logic                          swap,
    input  logic [23:0]                   rgb,
    input  logic                          hsync,
    input  logic                          vsync,
    input  logic                          active,
    input  logic                          test_done,
    input  int                            test_num,
    output int                            pending,
    output int                            error_total
);

    logic [RESULT_LINE_WIDTH-1:0] expected_q [$];   // One line per accepted operand
    logic [ITERS_GROUP_WIDTH-1:0] image [int];      // Both banks, keyed by bank and group
    word_t last_sum [LANE_COUNT];
    logic [FB_ADDR_WIDTH+ITERS_GROUP_WIDTH:0] write_d [2];
    logic [1:0] swap_d;
    logic rst_q   = 1'b0;
    logic vsync_q = 1'b0;
    logic shown   = 1'b0;   // Bank on screen
    logic armed   = 1'b0;
    int col       = 0;
    int line      = 0;
    int porch     = -1;     // Blank cycles since the last active pixel of a line
    int hsync_len = 0;
    int checks    = 0;
    int errors    = 0;
    int errors_all = 0;

    assign error_total = errors_all;

    task automatic compare(input string name, input logic [31:0] want, input logic [31:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            errors_all++;
            $display("Mismatch %s: expected %0h, got %0h", name, want, got);
        end
    endtask

    always @(posedge clk_pixel) begin : watch
        word_t a;
        word_t b;
        word_t c;
        logic signed [2*WORD_WIDTH-1:0] p;
        logic [RESULT_LINE_WIDTH-1:0] exp_line;
        int x;
        int y;
        int key;
        iters_t n;
        if (test_done) begin
            $display("test %0d finished: %0d checks, %0d errors", test_num, checks, errors);
            checks = 0;
            errors = 0;
        end
        if (rst_q && !sys_rst) begin    // First edge out of reset
            compare("result_valid", 0, result_valid);
            compare("operand_ready", 1, operand_ready);
            compare("active", 0, active);
            compare("hsync", 0, hsync);
            compare("vsync", 0, vsync);
        end
        rst_q = sys_rst;
        if (sys_rst) begin
            col        = 0;
            line       = 0;
            porch      = -1;
            hsync_len  = 0;
            shown      = 1'b0;
            armed      = 1'b0;
            swap_d     = '0;
            write_d[0] = '0;
            write_d[1] = '0;
            vsync_q    = 1'b0;
        end else begin
            if (result_valid && result_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    errors_all++;
                    $display("A result was delivered with no accepted operand outstanding");
                end else begin
                    exp_line = expected_q.pop_front();
                    for (int k = 0; k < LANE_COUNT; k++) begin
                        compare($sformatf("result_line lane %0d", k),
                                exp_line[RESULT_LINE_WIDTH-1-k*WORD_WIDTH -: WORD_WIDTH],
                                result_line[RESULT_LINE_WIDTH-1-k*WORD_WIDTH -: WORD_WIDTH]);
                    end
                end
            end
            if (operand_valid && operand_ready) begin
                for (int k = 0; k < LANE_COUNT; k++) begin
                    a = operand_line[OPERAND_LINE_WIDTH-1-k*3*WORD_WIDTH -: WORD_WIDTH];
                    b = operand_line[OPERAND_LINE_WIDTH-1-k*3*WORD_WIDTH-WORD_WIDTH -: WORD_WIDTH];
                    c = operand_line[OPERAND_LINE_WIDTH-1-k*3*WORD_WIDTH-2*WORD_WIDTH -: WORD_WIDTH];
                    p = a * b;
                    if (!use_new_c) begin
                        c = last_sum[k];    // Iterate on the previous result
                    end
                    last_sum[k] = word_t'(p >>> FIXED_POINT) + c;
                    exp_line[RESULT_LINE_WIDTH-1-k*WORD_WIDTH -: WORD_WIDTH] = last_sum[k];
                end
                expected_q.push_back(exp_line);
            end

            // Writes and swaps delayed two cycles to line up with the video pipeline
            if (write_d[1][FB_ADDR_WIDTH+ITERS_GROUP_WIDTH]) begin
                key = (shown ? 0 : FB_GROUPS) + write_d[1][ITERS_GROUP_WIDTH +: FB_ADDR_WIDTH];
                image[key] = write_d[1][ITERS_GROUP_WIDTH-1:0];
            end
            if (active) begin
                x   = col >> SCALE_SHIFT;
                y   = line >> SCALE_SHIFT;
                key = (shown ? FB_GROUPS : 0) + (y * FB_WIDTH + x) / GROUP_PIXELS;
                if (x >= FB_WIDTH || y >= FB_HEIGHT) begin
                    compare("rgb outside image", 0, rgb);
                end else if (image.exists(key)) begin
                    n = image[key][ITERS_GROUP_WIDTH-1-(x % GROUP_PIXELS)*ITERS_BITS -: ITERS_BITS];
                    compare($sformatf("rgb at image (%0d, %0d)", x, y),
                            {n, n, n, 4'h0, 8'hFF - {n, n}}, rgb);
                end
                if (col == 0 && line == 0) begin    // Bank flips after the frame-start pixel
                    shown = shown ^ armed;
                    armed = 1'b0;
                end
                col++;
            end else begin
                compare("rgb in blanking", 0, rgb);
                if (col != 0) begin
                    compare("active cycles per line", H_ACTIVE, col);
                    if (porch >= 0) begin
                        errors++;
                        errors_all++;
                        $display("No hsync pulse followed the previous active line");
                    end
                    col   = 0;
                    line++;
                    porch = 0;
                end
                if (porch >= 0 && hsync) begin
                    compare("hsync front porch", H_FRONT, porch);
                    porch = -1;
                end else if (porch >= 0) begin
                    porch++;
                end
            end
            if (hsync) begin
                hsync_len++;
            end else if (hsync_len != 0) begin
                compare("hsync pulse width", H_SYNC, hsync_len);
                hsync_len = 0;
            end
            if (vsync && !vsync_q) begin
                compare("active lines per frame", V_ACTIVE, line);
            end
            if (vsync) begin
                line = 0;
            end
            vsync_q = vsync;
            if (swap_d[1]) begin
                armed = 1'b1;
            end
            swap_d     = {swap_d[0], swap};
            write_d[1] = write_d[0];
            write_d[0] = {iters_valid, iters_addr, iters_group};
        end
        pending = expected_q.size();
    end

endmodule

// ==== logic/fractal_top.sv ====
`timescale 1ns/10ps

module fractal_top import fractal_pkg::*; (
    input  logic                          clk_pixel,
    input  logic                          sys_rst,

    // Operand stream into the FMA array
    input  logic                          operand_valid,
    output logic                          operand_ready,
    input  logic [OPERAND_LINE_WIDTH-1:0] operand_line,
    input  logic                          use_new_c,

    // Result stream
    output logic                          result_valid,
    input  logic                          result_ready,
    output logic [RESULT_LINE_WIDTH-1:0]  result_line,

    // Iteration count writes and bank swap
    input  logic                          iters_valid,
    input  logic [FB_ADDR_WIDTH-1:0]      iters_addr,
    input  logic [ITERS_GROUP_WIDTH-1:0]  iters_group,
    input  logic                          swap,

    // Video out
    output logic [7:0]                    red,
    output logic [7:0]                    green,
    output logic [7:0]                    blue,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          active
);

    hcount_t hcount;
    vcount_t vcount;
    logic    timing_hsync;       // Raw, before the frame buffer pipeline
    logic    timing_vsync;
    logic    timing_active;
    logic    frame_start;

    fma_array fma_array_i (
        .clk_pixel     (clk_pixel),
        .sys_rst       (sys_rst),
        .operand_valid (operand_valid),
        .operand_ready (operand_ready),
        .operand_line  (operand_line),
        .use_new_c     (use_new_c),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result_line   (result_line)
    );

    video_timing video_timing_i (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .hcount      (hcount),
        .vcount      (vcount),
        .hsync       (timing_hsync),
        .vsync       (timing_vsync),
        .active      (timing_active),
        .frame_start (frame_start)
    );

    frame_buffer frame_buffer_i (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .iters_valid (iters_valid),
        .iters_addr  (iters_addr),
        .iters_group (iters_group),
        .swap        (swap),
        .frame_start (frame_start),
        .hcount      (hcount),
        .vcount      (vcount),
        .hsync_in    (timing_hsync),
        .vsync_in    (timing_vsync),
        .active_in   (timing_active),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active)
    );

endmodule

// ==== video/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer import fractal_pkg::*; (
    input  logic                         clk_pixel,
    input  logic                         sys_rst,
    input  logic                         iters_valid,
    input  logic [FB_ADDR_WIDTH-1:0]     iters_addr,
    input  logic [ITERS_GROUP_WIDTH-1:0] iters_group,
    input  logic                         swap,
    input  logic                         frame_start,
    input  hcount_t                      hcount,
    input  vcount_t                      vcount,
    input  logic                         hsync_in,
    input  logic                         vsync_in,
    input  logic                         active_in,
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         active
);

    logic [ITERS_GROUP_WIDTH-1:0] bank0 [FB_GROUPS];
    logic [ITERS_GROUP_WIDTH-1:0] bank1 [FB_GROUPS];

    logic display_bank;     // Bank on screen, the other one takes writes
    logic swap_armed;

    hcount_t                   img_x;
    vcount_t                   img_y;
    logic                      in_bounds;
    logic [FB_ADDR_WIDTH-1:0]  rd_addr;

    logic [ITERS_GROUP_WIDTH-1:0] rd_group;
    logic [GROUP_SEL_BITS-1:0]    rd_pos;
    logic                         rd_in_bounds;
    logic                         hsync_q1;
    logic                         vsync_q1;
    logic                         active_q1;

    iters_t     pix_iters;
    logic [7:0] pal_red;
    logic [7:0] pal_green;
    logic [7:0] pal_blue;

    // Swap waits for the next frame start so a frame never tears
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            display_bank <= 1'b0;
            swap_armed   <= 1'b0;
        end else if (frame_start) begin
            display_bank <= display_bank ^ swap_armed;
            swap_armed   <= swap;
        end else if (swap) begin
            swap_armed <= 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (iters_valid && display_bank) begin
            bank0[iters_addr] <= iters_group;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (iters_valid && !display_bank) begin
            bank1[iters_addr] <= iters_group;
        end
    end

    // Screen to image coordinates
    assign img_x     = hcount >> SCALE_SHIFT;
    assign img_y     = vcount >> SCALE_SHIFT;
    assign in_bounds = (img_x < hcount_t'(FB_WIDTH)) && (img_y < vcount_t'(FB_HEIGHT));
    assign rd_addr   = in_bounds ?
        FB_ADDR_WIDTH'(img_y * FB_GROUPS_PER_ROW + (img_x >> GROUP_SEL_BITS)) : '0;

    // Stage 1 group read
    always_ff @(posedge clk_pixel) begin
        rd_group     <= display_bank ? bank1[rd_addr] : bank0[rd_addr];
        rd_pos       <= img_x[GROUP_SEL_BITS-1:0];
        rd_in_bounds <= in_bounds;
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            hsync_q1  <= 1'b0;
            vsync_q1  <= 1'b0;
            active_q1 <= 1'b0;
        end else begin
            hsync_q1  <= hsync_in;
            vsync_q1  <= vsync_in;
            active_q1 <= active_in;
        end
    end

    // Pixel 0 is the top nibble of its group
    always_comb begin
        pix_iters = rd_group[(GROUP_PIXELS - 1 - rd_pos) * ITERS_BITS +: ITERS_BITS];
        pal_red   = {pix_iters, pix_iters};
        pal_green = {pix_iters, {ITERS_BITS{1'b0}}};
        pal_blue  = 8'hFF - pal_red;
    end

    // Stage 2 colour, black outside the image or blanking
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            red    <= '0;
            green  <= '0;
            blue   <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end else begin
            red    <= (active_q1 && rd_in_bounds) ? pal_red   : 8'h00;
            green  <= (active_q1 && rd_in_bounds) ? pal_green : 8'h00;
            blue   <= (active_q1 && rd_in_bounds) ? pal_blue  : 8'h00;
            hsync  <= hsync_q1;
            vsync  <= vsync_q1;
            active <= active_q1;
        end
    end

endmodule

// ==== video/video_timing.sv ====
`timescale 1ns/10ps

module video_timing import fractal_pkg::*; (
    input  logic    clk_pixel,
    input  logic    sys_rst,
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    hsync,
    output logic    vsync,
    output logic    active,
    output logic    frame_start
);

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount == hcount_t'(H_TOTAL - 1));
    assign frame_end = (vcount == vcount_t'(V_TOTAL - 1));

    // Free-running raster counters
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (line_end) begin
                hcount <= '0;
                if (frame_end) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Sync pulses follow the front porch, active high
    always_comb begin
        hsync = (hcount >= hcount_t'(H_ACTIVE + H_FRONT)) &&
                (hcount <  hcount_t'(H_ACTIVE + H_FRONT + H_SYNC));
        vsync = (vcount >= vcount_t'(V_ACTIVE + V_FRONT)) &&
                (vcount <  vcount_t'(V_ACTIVE + V_FRONT + V_SYNC));
    end

    assign active      = (hcount < hcount_t'(H_ACTIVE)) && (vcount < vcount_t'(V_ACTIVE));
    assign frame_start = (hcount == '0) && (vcount == '0);   // One cycle per frame

endmodule

// ==== fma/fma_array.sv ====
`timescale 1ns/10ps

module fma_array import fractal_pkg::*; (
    input  logic                          clk_pixel,
    input  logic                          sys_rst,
    input  logic                          operand_valid,
    output logic                          operand_ready,
    input  logic [OPERAND_LINE_WIDTH-1:0] operand_line,
    input  logic                          use_new_c,
    output logic                          result_valid,
    input  logic                          result_ready,
    output logic [RESULT_LINE_WIDTH-1:0]  result_line
);

    word_t lane_a   [LANE_COUNT];
    word_t lane_b   [LANE_COUNT];
    word_t lane_c   [LANE_COUNT];
    word_t lane_sum [LANE_COUNT];
    logic [LANE_COUNT-1:0] lane_valid;

    logic enable;

    // All lanes run in lockstep, so lane 0 speaks for the array
    assign result_valid  = lane_valid[0];

    // Freeze the whole pipe while a result waits for the sink
    assign enable        = !result_valid || result_ready;
    assign operand_ready = enable;

    for (genvar k = 0; k < LANE_COUNT; k++) begin : gen_lane

        // Lane 0 sits at the top of the line, a above b above c
        assign lane_a[k] =
            operand_line[OPERAND_LINE_WIDTH - 1 - k*LANE_OPERAND_WIDTH -: WORD_WIDTH];
        assign lane_b[k] =
            operand_line[OPERAND_LINE_WIDTH - 1 - k*LANE_OPERAND_WIDTH - WORD_WIDTH
                         -: WORD_WIDTH];
        assign lane_c[k] =
            operand_line[OPERAND_LINE_WIDTH - 1 - k*LANE_OPERAND_WIDTH - 2*WORD_WIDTH
                         -: WORD_WIDTH];

        fma_lane lane_i (
            .clk_pixel (clk_pixel),
            .sys_rst   (sys_rst),
            .enable    (enable),
            .load      (operand_valid),
            .use_new_c (use_new_c),
            .a         (lane_a[k]),
            .b         (lane_b[k]),
            .c         (lane_c[k]),
            .sum       (lane_sum[k]),
            .sum_valid (lane_valid[k])
        );

        // Pack results, lane 0 in the top word
        assign result_line[RESULT_LINE_WIDTH - 1 - k*WORD_WIDTH -: WORD_WIDTH] = lane_sum[k];

    end

endmodule

// ==== fma/fma_lane.sv ====
`timescale 1ns/10ps

module fma_lane import fractal_pkg::*; (
    input  logic  clk_pixel,
    input  logic  sys_rst,
    input  logic  enable,      // Low holds both stages
    input  logic  load,
    input  logic  use_new_c,
    input  word_t a,
    input  word_t b,
    input  word_t c,
    output word_t sum,
    output logic  sum_valid
);

    logic signed [2*WORD_WIDTH-1:0] product;
    word_t product_shifted;

    word_t prod_q;
    word_t c_q;
    logic  new_c_q;
    logic  s1_valid;

    word_t feedback_q;      // Most recent adder result
    logic  s2_valid;

    // Full-width signed product, rescaled back to Q6.10
    assign product         = a * b;
    assign product_shifted = word_t'(product >>> FIXED_POINT);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (enable) begin
            s1_valid <= load;
            s2_valid <= s1_valid;
        end
    end

    // Stage 1 captures product and addend
    always_ff @(posedge clk_pixel) begin
        if (enable && load) begin
            prod_q  <= product_shifted;
            c_q     <= c;
            new_c_q <= use_new_c;
        end
    end

    // Stage 2 sum, wraps modulo 2^16
    always_ff @(posedge clk_pixel) begin
        if (enable && s1_valid) begin
            if (new_c_q) begin
                feedback_q <= prod_q + c_q;
            end else begin
                feedback_q <= prod_q + feedback_q;   // Iterate on own result
            end
        end
    end

    assign sum       = feedback_q;
    assign sum_valid = s2_valid;

endmodule

// ==== common/fractal_pkg.sv ====
package fractal_pkg;

    // FMA array
    localparam int WORD_WIDTH         = 16;
    localparam int FIXED_POINT        = 10;                   // Q6.10
    localparam int LANE_COUNT         = 16;
    localparam int LANE_OPERAND_WIDTH = 3 * WORD_WIDTH;       // a, b, c
    localparam int OPERAND_LINE_WIDTH = LANE_COUNT * LANE_OPERAND_WIDTH;
    localparam int RESULT_LINE_WIDTH  = LANE_COUNT * WORD_WIDTH;

    typedef logic signed [WORD_WIDTH-1:0] word_t;

    // Frame buffer
    localparam int ITERS_BITS        = 4;
    localparam int GROUP_PIXELS      = 16;                    // Counts per group
    localparam int GROUP_SEL_BITS    = $clog2(GROUP_PIXELS);
    localparam int ITERS_GROUP_WIDTH = GROUP_PIXELS * ITERS_BITS;
    localparam int FB_WIDTH          = 320;
    localparam int FB_HEIGHT         = 320;
    localparam int FB_GROUPS         = FB_WIDTH * FB_HEIGHT / GROUP_PIXELS;
    localparam int FB_GROUPS_PER_ROW = FB_WIDTH / GROUP_PIXELS;
    localparam int FB_ADDR_WIDTH     = $clog2(FB_GROUPS);
    localparam int SCALE_SHIFT       = 1;                     // 2x2 screen pixels per image pixel

    typedef logic [ITERS_BITS-1:0] iters_t;

    // 720p video timing
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 110;
    localparam int H_SYNC   = 40;
    localparam int H_BACK   = 220;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 720;
    localparam int V_FRONT  = 5;
    localparam int V_SYNC   = 5;
    localparam int V_BACK   = 20;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

endpackage
